//--- fetch_config.svh
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

//////////////////////////////////////////////////
// branch target buffer geometry
//////////////////////////////////////////////////

`define BTB_ENTRIES 16
`define BTB_IDX_W   4   // log2 of BTB_ENTRIES

//////////////////////////////////////////////////
// fetch queue and boot address
//////////////////////////////////////////////////

`define FQ_DEPTH    4               // packets, power of two
`define RESET_PC    32'h1c00_0000

`endif

//--- fetch_pkg.sv
`include "fetch_config.svh"

package fetch_pkg;

    // byte address as seen by fetch
    typedef logic [31:0] addr_t;

    // word-aligned target, low two bits dropped
    typedef logic [29:0] word_addr_t;

    // btb index taken from pc[BTB_IDX_W+1:2]
    typedef logic [`BTB_IDX_W-1:0] btb_idx_t;

    // everything above the index bits
    typedef logic [31-`BTB_IDX_W-2:0] btb_tag_t;

    // 2-bit saturating direction counter, msb means taken
    typedef logic [1:0] ctr_t;

    // bit 0 is the instr at pc, bit 1 the one at pc+4
    typedef logic [1:0] slot_mask_t;

endpackage

//--- fetch_if.sv
// combinational lookup, one result per fetch slot
interface btb_lookup_if import fetch_pkg::*; ();

    addr_t      lookup_pc;  // current fetch pc
    slot_mask_t hit_taken;  // per slot: valid, tag hit, counter says taken
    addr_t      target0;
    addr_t      target1;

    modport fetch (
        output lookup_pc,
        input  hit_taken,
        input  target0,
        input  target1
    );

    modport predictor (
        input  lookup_pc,
        output hit_taken,
        output target0,
        output target1
    );

endinterface

// packet push from pc gen into the fetch queue
interface fq_push_if import fetch_pkg::*; ();

    logic       push;           // only when !full && !flush
    addr_t      pkt_pc;
    slot_mask_t pkt_slots;
    addr_t      pkt_pred_npc;
    logic       flush;          // any redirect, wins over push
    logic       full;

    modport producer (
        output push, pkt_pc, pkt_slots, pkt_pred_npc, flush,
        input  full
    );

    modport queue (
        input  push, pkt_pc, pkt_slots, pkt_pred_npc, flush,
        output full
    );

endinterface

//--- branch_predictor.sv
`include "fetch_config.svh"

module branch_predictor import fetch_pkg::*; (
    input  logic            clk,
    input  logic            i_rst_n,
    btb_lookup_if.predictor lookup,
    input  logic            i_upd_valid,
    input  addr_t           i_upd_pc,
    input  addr_t           i_upd_target,
    input  logic            i_upd_taken
);

    logic [`BTB_ENTRIES-1:0] valid_q;
    btb_tag_t                tag_q    [`BTB_ENTRIES];
    ctr_t                    ctr_q    [`BTB_ENTRIES];
    word_addr_t              target_q [`BTB_ENTRIES];

    addr_t      slot_pc  [2];
    word_addr_t slot_tgt [2];

    btb_idx_t   upd_idx;
    btb_tag_t   upd_tag;
    logic       upd_hit;

    function automatic btb_idx_t idx_of(addr_t pc);
        return pc[`BTB_IDX_W+1:2];
    endfunction

    function automatic btb_tag_t tag_of(addr_t pc);
        return pc[31:`BTB_IDX_W+2];
    endfunction

    //////////////////////////////////////////////////
    // lookup, two read ports
    //////////////////////////////////////////////////

    assign slot_pc[0] = lookup.lookup_pc;
    assign slot_pc[1] = lookup.lookup_pc + 32'd4;   // second instr of the pair

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            lookup.hit_taken[s] = valid_q[idx_of(slot_pc[s])]
                               && tag_q[idx_of(slot_pc[s])] == tag_of(slot_pc[s])
                               && ctr_q[idx_of(slot_pc[s])][1];
            slot_tgt[s] = target_q[idx_of(slot_pc[s])];
        end
    end

    assign lookup.target0 = {slot_tgt[0], 2'b00};
    assign lookup.target1 = {slot_tgt[1], 2'b00};

    //////////////////////////////////////////////////
    // training from execute
    //////////////////////////////////////////////////

    assign upd_idx = idx_of(i_upd_pc);
    assign upd_tag = tag_of(i_upd_pc);
    assign upd_hit = valid_q[upd_idx] && tag_q[upd_idx] == upd_tag;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (i_upd_valid && !upd_hit && i_upd_taken) begin
            valid_q[upd_idx] <= 1'b1;   // allocate on taken miss
        end
    end

    always_ff @(posedge clk) begin
        if (i_upd_valid) begin
            if (upd_hit) begin
                target_q[upd_idx] <= i_upd_target[31:2];
                if (i_upd_taken && ctr_q[upd_idx] != 2'b11) begin
                    ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;
                end else if (!i_upd_taken && ctr_q[upd_idx] != 2'b00) begin
                    ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;
                end
            end else if (i_upd_taken) begin
                tag_q[upd_idx]    <= upd_tag;
                ctr_q[upd_idx]    <= 2'b10;     // weakly taken
                target_q[upd_idx] <= i_upd_target[31:2];
            end
        end
    end

endmodule

//--- fetch_pc_gen.sv
`include "fetch_config.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic        clk,
    input  logic        i_rst_n,
    btb_lookup_if.fetch lookup,
    fq_push_if.producer fq,
    input  logic        i_exc_valid,
    input  addr_t       i_eentry,
    input  logic        i_ertn_valid,
    input  addr_t       i_era,
    input  logic        i_br_valid,
    input  addr_t       i_br_pc
);

    addr_t      pc_q;
    addr_t      pred_npc;
    slot_mask_t pred_slots;
    logic       redirect;
    addr_t      redirect_pc;

    assign lookup.lookup_pc = pc_q;

    // slot 0 taken kills slot 1
    always_comb begin
        if (lookup.hit_taken[0]) begin
            pred_npc   = lookup.target0;
            pred_slots = 2'b01;
        end else if (lookup.hit_taken[1]) begin
            pred_npc   = lookup.target1;
            pred_slots = 2'b11;
        end else begin
            pred_npc   = pc_q + 32'd8;  // fall through past the pair
            pred_slots = 2'b11;
        end
    end

    //////////////////////////////////////////////////
    // redirects, exception > ertn > branch
    //////////////////////////////////////////////////

    assign redirect = i_exc_valid | i_ertn_valid | i_br_valid;

    always_comb begin
        if (i_exc_valid)       redirect_pc = i_eentry;
        else if (i_ertn_valid) redirect_pc = i_era;
        else                   redirect_pc = i_br_pc;
    end

    assign fq.flush        = redirect;
    assign fq.push         = !redirect && !fq.full;
    assign fq.pkt_pc       = pc_q;
    assign fq.pkt_slots    = pred_slots;
    assign fq.pkt_pred_npc = pred_npc;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (fq.push) begin
            pc_q <= pred_npc;   // hold while the queue is full
        end
    end

endmodule

//--- fetch_queue.sv
`include "fetch_config.svh"

module fetch_queue import fetch_pkg::*; #(
    parameter int DEPTH = `FQ_DEPTH
) (
    input  logic       clk,
    input  logic       i_rst_n,
    fq_push_if.queue   fq,
    input  logic       i_issue_stall,
    output logic       o_pkt_valid,
    output addr_t      o_pkt_pc,
    output slot_mask_t o_pkt_slots,
    output addr_t      o_pkt_pred_npc
);

    localparam int             PTR_W    = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = DEPTH[PTR_W:0];

    addr_t      pc_mem    [DEPTH];
    slot_mask_t slots_mem [DEPTH];
    addr_t      npc_mem   [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;    // occupancy, 0..DEPTH
    logic             pop;

    assign o_pkt_valid    = count != '0;
    assign fq.full        = count == FULL_CNT;
    assign pop            = o_pkt_valid && !i_issue_stall;

    assign o_pkt_pc       = pc_mem[rd_ptr];
    assign o_pkt_slots    = slots_mem[rd_ptr];
    assign o_pkt_pred_npc = npc_mem[rd_ptr];

    //////////////////////////////////////////////////
    // pointers and count
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (fq.flush) begin
            rd_ptr <= '0;   // drop everything in flight
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (fq.push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)     rd_ptr <= rd_ptr + 1'b1;
            case ({fq.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // packet storage
    always_ff @(posedge clk) begin
        if (fq.push && !fq.flush) begin
            pc_mem[wr_ptr]    <= fq.pkt_pc;
            slots_mem[wr_ptr] <= fq.pkt_slots;
            npc_mem[wr_ptr]   <= fq.pkt_pred_npc;
        end
    end

endmodule

//--- fetch_frontend.sv
module fetch_frontend import fetch_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    // redirects
    input  logic       i_exc_valid,
    input  addr_t      i_eentry,
    input  logic       i_ertn_valid,
    input  addr_t      i_era,
    input  logic       i_br_valid,
    input  addr_t      i_br_pc,
    // btb training
    input  logic       i_upd_valid,
    input  addr_t      i_upd_pc,
    input  addr_t      i_upd_target,
    input  logic       i_upd_taken,
    // packet out
    input  logic       i_issue_stall,
    output logic       o_pkt_valid,
    output addr_t      o_pkt_pc,
    output slot_mask_t o_pkt_slots,
    output addr_t      o_pkt_pred_npc
);

    btb_lookup_if lookup_bus ();
    fq_push_if    fq_bus ();

    fetch_pc_gen fetch_pc_gen_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .lookup       (lookup_bus),
        .fq           (fq_bus),
        .i_exc_valid  (i_exc_valid),
        .i_eentry     (i_eentry),
        .i_ertn_valid (i_ertn_valid),
        .i_era        (i_era),
        .i_br_valid   (i_br_valid),
        .i_br_pc      (i_br_pc)
    );

    branch_predictor branch_predictor_i (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .lookup       (lookup_bus),
        .i_upd_valid  (i_upd_valid),
        .i_upd_pc     (i_upd_pc),
        .i_upd_target (i_upd_target),
        .i_upd_taken  (i_upd_taken)
    );

    fetch_queue fetch_queue_i (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .fq             (fq_bus),
        .i_issue_stall  (i_issue_stall),
        .o_pkt_valid    (o_pkt_valid),
        .o_pkt_pc       (o_pkt_pc),
        .o_pkt_slots    (o_pkt_slots),
        .o_pkt_pred_npc (o_pkt_pred_npc)
    );

endmodule

//--- fetch_frontend_assertions.sv
module fetch_frontend_assertions import fetch_pkg::*; #(
    parameter int DEPTH = 4
) (
    input logic                   clk,
    input logic                   i_rst_n,
    input logic                   i_pkt_valid,
    input logic                   i_flush,
    input logic [$clog2(DEPTH):0] i_count
);

    //////////////////////////////////////////////////
    // fetch queue properties
    //////////////////////////////////////////////////

    // nothing leaves the queue while in reset
    a_reset_quiet: assert property (@(posedge clk) !i_rst_n |-> !i_pkt_valid)
        else $error("fetch queue output valid during reset");

    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n) i_count <= DEPTH)
        else $error("fetch queue occupancy above depth");

    a_flush_empties: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_flush |=> !i_pkt_valid)
        else $error("fetch queue not empty after flush");

endmodule

bind fetch_queue fetch_frontend_assertions #(.DEPTH(DEPTH)) fetch_queue_sva_i (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_pkt_valid (o_pkt_valid),
    .i_flush     (fq.flush),
    .i_count     (count)
);

//--- tb_fetch_frontend.sv
`include "fetch_config.svh"

module tb_fetch_frontend import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RAND_CYCLES    = 1500;
    localparam int TIMEOUT_CYCLES = 2000;   // directed phases ~80 + random + margin

    logic       clk;
    logic       i_rst_n;
    logic       i_exc_valid, i_ertn_valid, i_br_valid;
    addr_t      i_eentry, i_era, i_br_pc;
    logic       i_upd_valid, i_upd_taken;
    addr_t      i_upd_pc, i_upd_target;
    logic       i_issue_stall;
    logic       o_pkt_valid;
    addr_t      o_pkt_pc, o_pkt_pred_npc;
    slot_mask_t o_pkt_slots;

    // reference model state
    logic       m_valid [`BTB_ENTRIES];
    btb_tag_t   m_tag   [`BTB_ENTRIES];
    ctr_t       m_ctr   [`BTB_ENTRIES];
    addr_t      m_tgt   [`BTB_ENTRIES];
    addr_t      m_pc;
    addr_t      q_pc    [$];
    slot_mask_t q_slots [$];
    addr_t      q_npc   [$];

    string  test_name = "init";
    int     errors = 0;
    int     checks = 0;
    int     cycles = 0;
    integer seed = 32'h8b2c_2a32;

    fetch_frontend fetch_frontend_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_addr(string what, addr_t exp, addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_slots(string what, slot_mask_t exp, slot_mask_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_valid(string what, logic exp, logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic predicts(addr_t pc);
        btb_idx_t i;
        i = pc[`BTB_IDX_W+1:2];
        return m_valid[i] && m_tag[i] == pc[31:`BTB_IDX_W+2] && m_ctr[i][1];
    endfunction

    // one clock edge, inputs as they stood before the edge
    task automatic update_model();
        addr_t      pc1;
        addr_t      npc;
        slot_mask_t slots;
        btb_idx_t   ui;
        logic       full;
        pc1 = m_pc + 32'd4;
        if (predicts(m_pc)) begin
            npc   = m_tgt[m_pc[`BTB_IDX_W+1:2]];
            slots = 2'b01;                          // slot 1 squashed
        end else if (predicts(pc1)) begin
            npc   = m_tgt[pc1[`BTB_IDX_W+1:2]];
            slots = 2'b11;
        end else begin
            npc   = m_pc + 32'd8;
            slots = 2'b11;
        end
        if (i_exc_valid || i_ertn_valid || i_br_valid) begin
            q_pc.delete();
            q_slots.delete();
            q_npc.delete();
            m_pc = i_exc_valid ? i_eentry : (i_ertn_valid ? i_era : i_br_pc);
        end else begin
            full = q_pc.size() == `FQ_DEPTH;
            if (q_pc.size() != 0 && !i_issue_stall) begin
                void'(q_pc.pop_front());
                void'(q_slots.pop_front());
                void'(q_npc.pop_front());
            end
            if (!full) begin
                q_pc.push_back(m_pc);
                q_slots.push_back(slots);
                q_npc.push_back(npc);
                m_pc = npc;
            end
        end
        if (i_upd_valid) begin
            ui = i_upd_pc[`BTB_IDX_W+1:2];
            if (m_valid[ui] && m_tag[ui] == i_upd_pc[31:`BTB_IDX_W+2]) begin
                m_tgt[ui] = {i_upd_target[31:2], 2'b00};
                if (i_upd_taken && m_ctr[ui] != 2'b11) m_ctr[ui] = m_ctr[ui] + 2'd1;
                else if (!i_upd_taken && m_ctr[ui] != 2'b00) m_ctr[ui] = m_ctr[ui] - 2'd1;
            end else if (i_upd_taken) begin
                m_valid[ui] = 1'b1;
                m_tag[ui]   = i_upd_pc[31:`BTB_IDX_W+2];
                m_ctr[ui]   = 2'b10;
                m_tgt[ui]   = {i_upd_target[31:2], 2'b00};
            end
        end
    endtask

    // head packet checked mid cycle, popped ones in full
    always @(negedge clk) begin
        if (i_rst_n) begin
            check_valid("pkt_valid", q_pc.size() != 0, o_pkt_valid);
            if (q_pc.size() != 0 && !i_issue_stall) begin
                check_addr("pkt_pc", q_pc[0], o_pkt_pc);
                check_slots("pkt_slots", q_slots[0], o_pkt_slots);
                check_addr("pkt_pred_npc", q_npc[0], o_pkt_pred_npc);
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        update_model();
    endtask

    task automatic idle(int n);
        repeat (n) tick();
    endtask

    task automatic train(addr_t pc, addr_t tgt, logic taken);
        i_upd_valid  <= 1'b1;
        i_upd_pc     <= pc;
        i_upd_target <= tgt;
        i_upd_taken  <= taken;
        tick();
        i_upd_valid  <= 1'b0;
    endtask

    task automatic redirect(logic exc, logic ertn, logic br, addr_t ee, addr_t era, addr_t bpc);
        i_exc_valid  <= exc;
        i_ertn_valid <= ertn;
        i_br_valid   <= br;
        i_eentry     <= ee;
        i_era        <= era;
        i_br_pc      <= bpc;
        tick();
        i_exc_valid  <= 1'b0;
        i_ertn_valid <= 1'b0;
        i_br_valid   <= 1'b0;
    endtask

    function automatic addr_t rand_pc();
        return 32'h1c00_0000 | ($random(seed) & 32'h0000_01fc);  // small window, many hits
    endfunction

    task automatic random_cycle();
        logic [31:0] r;
        r = $random(seed);
        i_issue_stall <= r[1:0] == 2'b00;
        i_exc_valid   <= r[7:2] == 6'd0;
        i_ertn_valid  <= r[7:2] == 6'd1;
        i_br_valid    <= r[6:3] == 4'd7;
        i_eentry      <= rand_pc();
        i_era         <= rand_pc();
        i_br_pc       <= rand_pc();
        i_upd_valid   <= r[10:8] < 3'd3;
        i_upd_taken   <= r[11] | r[12];
        i_upd_pc      <= rand_pc();
        i_upd_target  <= rand_pc();
        tick();
    endtask

    task automatic report();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
    endtask

    initial begin
        i_rst_n = 1'b0;
        {i_exc_valid, i_ertn_valid, i_br_valid, i_upd_valid, i_upd_taken} = '0;
        {i_eentry, i_era, i_br_pc, i_upd_pc, i_upd_target} = '0;
        i_issue_stall = 1'b0;
        m_pc = `RESET_PC;
        for (int i = 0; i < `BTB_ENTRIES; i++) m_valid[i] = 1'b0;
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;

        test_name = "reset";
        idle(4);
        test_name = "backpressure";
        i_issue_stall <= 1'b1;
        idle(10);
        i_issue_stall <= 1'b0;
        idle(8);
        test_name = "trained";
        train(32'h1c00_1000, 32'h1c00_1040, 1'b1);  // slot 0 hit at 1000
        train(32'h1c00_1044, 32'h1c00_1000, 1'b1);  // slot 1 hit at 1040
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h1c00_1000);
        idle(12);
        test_name = "hysteresis";
        train(32'h1c00_1000, 32'h1c00_1040, 1'b0);
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h1c00_1000);
        idle(6);
        train(32'h1c00_1044, 32'h1c00_1000, 1'b1);  // now saturated
        train(32'h1c00_1044, 32'h1c00_1000, 1'b0);
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h1c00_1040);
        idle(6);
        train(32'h1c00_1044, 32'h1c00_1000, 1'b0);
        redirect(1'b0, 1'b0, 1'b1, '0, '0, 32'h1c00_1040);
        idle(6);
        test_name = "priority";
        i_issue_stall <= 1'b1;
        idle(6);
        redirect(1'b1, 1'b1, 1'b1, 32'h1c00_0800, 32'h1c00_0900, 32'h1c00_0a00);
        i_issue_stall <= 1'b0;
        idle(8);
        test_name = "random";
        repeat (RAND_CYCLES) random_cycle();

        @(negedge clk);
        #1;
        report();
        $finish;
    end

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        errors++;
        report();
        $finish;
    end

endmodule

//--- fetch_frontend.f
+incdir+.
fetch_pkg.sv
fetch_if.sv
branch_predictor.sv
fetch_pc_gen.sv
fetch_queue.sv
fetch_frontend.sv
fetch_frontend_assertions.sv
tb_fetch_frontend.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f fetch_frontend.f --top-module tb_fetch_frontend \
    --Mdir obj_dir -o sim_fetch_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_fetch_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    exit 1
fi
exit 0
